// File: design/datapathPkg.sv
//##########################################################################
// shared definitions for the single-bus datapath: word types, ALU
// operations, bus source enables, load enables and the control word
//##########################################################################
package datapathPkg;

    localparam int wordBits  = 32;
    localparam int gprCount  = 16;
    localparam int wideBits  = 2 * wordBits;
    localparam int shiftBits = $clog2(wordBits); // shift amount width, 5

    typedef logic [wordBits-1:0] word_t;
    typedef logic [wideBits-1:0] wide_t;
    typedef logic [gprCount-1:0] gprSel_t; // one-hot, bit i is R[i]

    typedef enum logic [3:0] {
        opNone = 4'd0,
        opAdd  = 4'd1,
        opSub  = 4'd2,
        opMul  = 4'd3,
        opDiv  = 4'd4,
        opShr  = 4'd5,
        opShl  = 4'd6,
        opRor  = 4'd7,
        opRol  = 4'd8,
        opAnd  = 4'd9,
        opOr   = 4'd10,
        opNeg  = 4'd11,
        opNot  = 4'd12,
        opInc  = 4'd13
    } aluOp_t;

    // one enable per bus driver
    typedef struct packed {
        gprSel_t gprOut;
        logic    pcOut;
        logic    mdrOut;
        logic    rzLoOut;
        logic    rzHiOut;
        logic    hiOut;
        logic    loOut;
        logic    inportOut;
    } busSrc_t;

    typedef struct packed {
        gprSel_t gprIn;
        logic    pcIn;
        logic    irIn;
        logic    marIn;
        logic    mdrIn;
        logic    ryIn;
        logic    rzIn;
        logic    hiIn;
        logic    loIn;
        logic    outputIn;
        logic    read;     // MDR takes memory data instead of the bus
    } loadCtl_t;

    typedef struct packed {
        busSrc_t  src;
        loadCtl_t load;
        aluOp_t   aluOp;
    } controlWord_t;

endpackage

// File: design/registerFile.sv
//##########################################################################
// sixteen general registers written from the bus
//##########################################################################
module registerFile (
    input  logic                 clk,
    input  logic                 reset,
    input  datapathPkg::gprSel_t gprIn,
    input  datapathPkg::word_t   bus,
    output datapathPkg::word_t   gprValues [0:datapathPkg::gprCount-1]
);

    datapathPkg::word_t regs [0:datapathPkg::gprCount-1];

    // several registers may load the same bus word in one cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < datapathPkg::gprCount; i++) begin
            if (reset) begin
                regs[i] <= '0;
            end else if (gprIn[i]) begin
                regs[i] <= bus;
            end
        end
    end

    // read side feeds the bus selector
    always_comb begin
        for (int i = 0; i < datapathPkg::gprCount; i++) begin
            gprValues[i] = regs[i];
        end
    end

endmodule

// File: design/alu.sv
//##########################################################################
// combinational ALU, 64-bit result from RY and the bus
//##########################################################################
module alu (
    input  datapathPkg::word_t  a,      // RY
    input  datapathPkg::word_t  b,      // bus
    input  datapathPkg::aluOp_t op,
    output datapathPkg::wide_t  result
);

    logic [datapathPkg::shiftBits-1:0] amount;
    datapathPkg::wide_t                doubled;
    datapathPkg::wide_t                rotRight;
    datapathPkg::wide_t                rotLeft;
    logic signed [datapathPkg::wideBits-1:0] product;
    datapathPkg::word_t                quotient;
    datapathPkg::word_t                remainder;
    datapathPkg::word_t                lowWord;
    logic                              divOverflow;

    assign amount = b[datapathPkg::shiftBits-1:0];

    // rotates come from a doubled copy of a
    assign doubled  = {a, a};
    assign rotRight = doubled >> amount;
    assign rotLeft  = doubled << amount;

    // both operands sign extend to the full 64 bits
    assign product = $signed(a) * $signed(b);

    // most negative word divided by minus one
    assign divOverflow = (a == {1'b1, {(datapathPkg::wordBits - 1){1'b0}}}) && (b == '1);

    always_comb begin
        if (b == '0) begin
            quotient  = '1;
            remainder = a;
        end else if (divOverflow) begin
            quotient  = a;  // wraps back to itself
            remainder = '0;
        end else begin
            quotient  = datapathPkg::word_t'($signed(a) / $signed(b));
            remainder = datapathPkg::word_t'($signed(a) % $signed(b));
        end
    end

    always_comb begin
        case (op)
            datapathPkg::opAdd: begin
                lowWord = a + b;
            end
            datapathPkg::opSub: begin
                lowWord = a - b;
            end
            datapathPkg::opShr: begin
                lowWord = a >> amount;  // logical
            end
            datapathPkg::opShl: begin
                lowWord = a << amount;
            end
            datapathPkg::opRor: begin
                lowWord = rotRight[datapathPkg::wordBits-1:0];
            end
            datapathPkg::opRol: begin
                lowWord = rotLeft[datapathPkg::wideBits-1:datapathPkg::wordBits];
            end
            datapathPkg::opAnd: begin
                lowWord = a & b;
            end
            datapathPkg::opOr: begin
                lowWord = a | b;
            end
            datapathPkg::opNeg: begin
                lowWord = -b;
            end
            datapathPkg::opNot: begin
                lowWord = ~b;
            end
            datapathPkg::opInc: begin
                lowWord = b + 1'b1;     // PC increment
            end
            default: begin
                lowWord = '0;           // opNone, mul and div
            end
        endcase
    end

    always_comb begin
        case (op)
            datapathPkg::opMul: begin
                result = datapathPkg::wide_t'(product);
            end
            datapathPkg::opDiv: begin
                result = {remainder, quotient};
            end
            default: begin
                result = {{datapathPkg::wordBits{1'b0}}, lowWord};
            end
        endcase
    end

endmodule

// File: design/busSelect.sv
//##########################################################################
// bus source selection by fixed priority
//##########################################################################
module busSelect (
    input  datapathPkg::busSrc_t src,
    input  datapathPkg::word_t   gprValues [0:datapathPkg::gprCount-1],
    input  datapathPkg::word_t   pcValue,
    input  datapathPkg::word_t   mdrValue,
    input  datapathPkg::wide_t   rzValue,
    input  datapathPkg::word_t   hiValue,
    input  datapathPkg::word_t   loValue,
    input  datapathPkg::word_t   inportData,
    output datapathPkg::word_t   bus
);

    datapathPkg::word_t gprWord;

    // scan downward so the lowest enabled index is left in gprWord
    always_comb begin
        gprWord = '0;
        for (int i = datapathPkg::gprCount - 1; i >= 0; i--) begin
            if (src.gprOut[i]) begin
                gprWord = gprValues[i];
            end
        end
    end

    always_comb begin
        if (|src.gprOut) begin
            bus = gprWord;
        end else if (src.pcOut) begin
            bus = pcValue;
        end else if (src.mdrOut) begin
            bus = mdrValue;
        end else if (src.rzLoOut) begin
            bus = rzValue[datapathPkg::wordBits-1:0];
        end else if (src.rzHiOut) begin
            bus = rzValue[datapathPkg::wideBits-1:datapathPkg::wordBits];
        end else if (src.hiOut) begin
            bus = hiValue;
        end else if (src.loOut) begin
            bus = loValue;
        end else if (src.inportOut) begin
            bus = inportData;
        end else begin
            bus = '0;   // idle bus reads as zero
        end
    end

endmodule

// File: design/specialRegs.sv
//##########################################################################
// named datapath registers: PC, IR, MAR, MDR, RY, RZ, HI, LO, output port
//##########################################################################
module specialRegs (
    input  logic                  clk,
    input  logic                  reset,
    input  datapathPkg::loadCtl_t load,
    input  datapathPkg::word_t    bus,
    input  datapathPkg::word_t    mdataIn,
    input  datapathPkg::wide_t    aluResult,
    output datapathPkg::word_t    pcValue,
    output datapathPkg::word_t    irValue,
    output datapathPkg::word_t    marValue,
    output datapathPkg::word_t    mdrValue,
    output datapathPkg::word_t    ryValue,
    output datapathPkg::word_t    hiValue,
    output datapathPkg::word_t    loValue,
    output datapathPkg::word_t    outputPort,
    output datapathPkg::wide_t    rzValue
);

    datapathPkg::word_t mdrNext;

    assign mdrNext = load.read ? mdataIn : bus;

    // program flow and memory interface
    always_ff @(posedge clk) begin
        if (reset) begin
            pcValue  <= '0;
            irValue  <= '0;
            marValue <= '0;
            mdrValue <= '0;
        end else begin
            if (load.pcIn) begin
                pcValue <= bus;
            end
            if (load.irIn) begin
                irValue <= bus;
            end
            if (load.marIn) begin
                marValue <= bus;
            end
            if (load.mdrIn) begin
                mdrValue <= mdrNext;
            end
        end
    end

    // ALU operand and result side
    always_ff @(posedge clk) begin
        if (reset) begin
            ryValue    <= '0;
            rzValue    <= '0;
            hiValue    <= '0;
            loValue    <= '0;
            outputPort <= '0;
        end else begin
            if (load.ryIn) begin
                ryValue <= bus;
            end
            if (load.rzIn) begin
                rzValue <= aluResult;   // both halves at once
            end
            if (load.hiIn) begin
                hiValue <= bus;
            end
            if (load.loIn) begin
                loValue <= bus;
            end
            if (load.outputIn) begin
                outputPort <= bus;
            end
        end
    end

endmodule

// File: design/datapath.sv
//##########################################################################
// single-bus datapath top: register file, named registers, ALU, bus select
//##########################################################################
module datapath (
    input  logic                      clk,
    input  logic                      reset,
    input  datapathPkg::controlWord_t ctrl,
    input  datapathPkg::word_t        mdataIn,
    input  datapathPkg::word_t        inportData,
    output datapathPkg::word_t        busValue,
    output datapathPkg::word_t        pcValue,
    output datapathPkg::word_t        irValue,
    output datapathPkg::word_t        marValue,
    output datapathPkg::word_t        outputPort
);

    datapathPkg::word_t bus;
    datapathPkg::word_t gprValues [0:datapathPkg::gprCount-1];
    datapathPkg::word_t mdrValue;
    datapathPkg::word_t ryValue;
    datapathPkg::word_t hiValue;
    datapathPkg::word_t loValue;
    datapathPkg::wide_t rzValue;
    datapathPkg::wide_t aluResult;

    assign busValue = bus;

    registerFile u_registerFile (
        .clk       (clk),
        .reset     (reset),
        .gprIn     (ctrl.load.gprIn),
        .bus       (bus),
        .gprValues (gprValues)
    );

    specialRegs u_specialRegs (
        .clk        (clk),
        .reset      (reset),
        .load       (ctrl.load),
        .bus        (bus),
        .mdataIn    (mdataIn),
        .aluResult  (aluResult),
        .pcValue    (pcValue),
        .irValue    (irValue),
        .marValue   (marValue),
        .mdrValue   (mdrValue),
        .ryValue    (ryValue),
        .hiValue    (hiValue),
        .loValue    (loValue),
        .outputPort (outputPort),
        .rzValue    (rzValue)
    );

    alu u_alu (
        .a      (ryValue),
        .b      (bus),
        .op     (ctrl.aluOp),
        .result (aluResult)
    );

    busSelect u_busSelect (
        .src        (ctrl.src),
        .gprValues  (gprValues),
        .pcValue    (pcValue),
        .mdrValue   (mdrValue),
        .rzValue    (rzValue),
        .hiValue    (hiValue),
        .loValue    (loValue),
        .inportData (inportData),
        .bus        (bus)
    );

endmodule

// File: testbench/datapathTb.sv
//##########################################################################
// datapath testbench with clock, reset, LFSR stimulus, reference model,
// compare tasks and watchdog
//##########################################################################
module datapathTb;

    localparam int clkPeriod = 20;
    localparam int opCount   = 300;
    localparam int timeLimit = opCount * 8 * clkPeriod + 100 * clkPeriod;
    localparam logic [31:0] lfsrSeed = 32'd77744;
    localparam logic [31:0] lfsrTaps = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

    logic                      clk;
    logic                      reset;
    datapathPkg::controlWord_t ctrl;
    datapathPkg::word_t        mdataIn;
    datapathPkg::word_t        inportData;
    datapathPkg::word_t        busValue;
    datapathPkg::word_t        pcValue;
    datapathPkg::word_t        irValue;
    datapathPkg::word_t        marValue;
    datapathPkg::word_t        outputPort;

    logic [31:0]        lfsrState;
    datapathPkg::word_t busSample;  // bus seen mid-cycle by runCycle

    // reference model
    datapathPkg::word_t mGpr [0:datapathPkg::gprCount-1];
    datapathPkg::word_t mPc;
    datapathPkg::word_t mIr;
    datapathPkg::word_t mMar;
    datapathPkg::word_t mMdr;
    datapathPkg::word_t mRy;
    datapathPkg::word_t mHi;
    datapathPkg::word_t mLo;
    datapathPkg::word_t mOut;
    datapathPkg::wide_t mRz;

    datapathPkg::aluOp_t simpleOps [0:11] = '{
        datapathPkg::opNone, datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opShr,
        datapathPkg::opShl, datapathPkg::opRor, datapathPkg::opRol, datapathPkg::opAnd,
        datapathPkg::opOr, datapathPkg::opNeg, datapathPkg::opNot, datapathPkg::opInc
    };

    datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .mdataIn    (mdataIn),
        .inportData (inportData),
        .busValue   (busValue),
        .pcValue    (pcValue),
        .irValue    (irValue),
        .marValue   (marValue),
        .outputPort (outputPort)
    );

    always #(clkPeriod / 2) clk = ~clk;

    initial begin
        #(timeLimit);
        abortRun("watchdog expired before all tests finished, the run timed out");
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrTaps) : (lfsrState >> 1);
        end
        return value;
    endfunction

    task automatic checkWord(input datapathPkg::word_t expected,
                             input datapathPkg::word_t actual, input string what);
        if (actual !== expected) begin
            abortRun($sformatf("FAIL %0t: %s expected %h, got %h",
                               $time, what, expected, actual));
        end
    endtask

    task automatic checkWide(input datapathPkg::wide_t expected,
                             input datapathPkg::wide_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("FAIL %0t: RZ pair expected %h, got %h",
                               $time, expected, actual));
        end
    endtask

    function automatic datapathPkg::wide_t aluModel(input datapathPkg::word_t a,
                                                    input datapathPkg::word_t b,
                                                    input datapathPkg::aluOp_t op);
        int                 n;
        longint             sa;
        longint             sb;
        datapathPkg::word_t low;
        n   = int'(b[4:0]);
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        low = '0;
        case (op)
            datapathPkg::opMul: return datapathPkg::wide_t'(sa * sb);
            datapathPkg::opDiv: begin
                if (b == '0) begin
                    return {a, 32'hFFFF_FFFF};
                end
                return {datapathPkg::word_t'(sa % sb), datapathPkg::word_t'(sa / sb)};
            end
            datapathPkg::opAdd: low = a + b;
            datapathPkg::opSub: low = a - b;
            datapathPkg::opShr: low = a >> n;
            datapathPkg::opShl: low = a << n;
            datapathPkg::opRor: low = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
            datapathPkg::opRol: low = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
            datapathPkg::opAnd: low = a & b;
            datapathPkg::opOr:  low = a | b;
            datapathPkg::opNeg: low = -b;
            datapathPkg::opNot: low = ~b;
            datapathPkg::opInc: low = b + 1;
            default:            low = '0;
        endcase
        return {32'h0, low};
    endfunction

    function automatic datapathPkg::word_t busFromModel(input datapathPkg::busSrc_t src);
        datapathPkg::word_t value;
        logic               found;
        value = '0;
        found = 1'b0;
        for (int i = 0; i < datapathPkg::gprCount; i++) begin
            if (src.gprOut[i] && !found) begin
                value = mGpr[i];
                found = 1'b1;
            end
        end
        if (!found) begin
            if (src.pcOut)          value = mPc;
            else if (src.mdrOut)    value = mMdr;
            else if (src.rzLoOut)   value = mRz[31:0];
            else if (src.rzHiOut)   value = mRz[63:32];
            else if (src.hiOut)     value = mHi;
            else if (src.loOut)     value = mLo;
            else if (src.inportOut) value = inportData;
        end
        return value;
    endfunction

    task automatic updateModel(input datapathPkg::controlWord_t cw,
                               input datapathPkg::word_t b);
        datapathPkg::wide_t result;
        result = aluModel(mRy, b, cw.aluOp);   // uses RY before this edge
        for (int i = 0; i < datapathPkg::gprCount; i++) begin
            if (cw.load.gprIn[i]) mGpr[i] = b;
        end
        if (cw.load.pcIn)     mPc  = b;
        if (cw.load.irIn)     mIr  = b;
        if (cw.load.marIn)    mMar = b;
        if (cw.load.mdrIn)    mMdr = cw.load.read ? mdataIn : b;
        if (cw.load.ryIn)     mRy  = b;
        if (cw.load.rzIn)     mRz  = result;
        if (cw.load.hiIn)     mHi  = b;
        if (cw.load.loIn)     mLo  = b;
        if (cw.load.outputIn) mOut = b;
    endtask

    task automatic clearModel();
        for (int i = 0; i < datapathPkg::gprCount; i++) begin
            mGpr[i] = '0;
        end
        {mPc, mIr, mMar, mMdr, mRy, mHi, mLo, mOut} = '0;
        mRz = '0;
    endtask

    // one control word for one clock with the bus sampled mid-cycle
    task automatic runCycle(input datapathPkg::controlWord_t cw);
        datapathPkg::word_t driven;
        ctrl = cw;
        driven = busFromModel(cw.src);
        @(negedge clk);
        busSample = busValue;
        updateModel(cw, driven);
        @(posedge clk);
        #2;
    endtask

    task automatic loadRegister(input int idx, input datapathPkg::word_t value);
        datapathPkg::controlWord_t cw;
        mdataIn = value;
        cw = '0;
        cw.load.mdrIn = 1'b1;
        cw.load.read  = 1'b1;
        runCycle(cw);
        cw = '0;
        cw.src.mdrOut = 1'b1;
        cw.load.gprIn[idx] = 1'b1;
        runCycle(cw);
    endtask

    task automatic readRegister(input int idx, output datapathPkg::word_t value);
        datapathPkg::controlWord_t cw;
        cw = '0;
        cw.src.gprOut[idx] = 1'b1;
        runCycle(cw);
        value = busSample;
    endtask

    // RY from R[a], RZ from R[b]
    task automatic startAluOp(input int a, input int b, input datapathPkg::aluOp_t op);
        datapathPkg::controlWord_t cw;
        cw = '0;
        cw.src.gprOut[a] = 1'b1;
        cw.load.ryIn = 1'b1;
        runCycle(cw);
        cw = '0;
        cw.src.gprOut[b] = 1'b1;
        cw.load.rzIn = 1'b1;
        cw.aluOp = op;
        runCycle(cw);
    endtask

    task automatic readRz(output datapathPkg::wide_t value);
        datapathPkg::controlWord_t cw;
        cw = '0;
        cw.src.rzLoOut = 1'b1;
        runCycle(cw);
        value[31:0] = busSample;
        cw = '0;
        cw.src.rzHiOut = 1'b1;
        runCycle(cw);
        value[63:32] = busSample;
    endtask

    task automatic checkPorts();
        checkWord(mPc, pcValue, "PC");
        checkWord(mIr, irValue, "IR");
        checkWord(mMar, marValue, "MAR");
        checkWord(mOut, outputPort, "output port");
    endtask

    initial begin
        datapathPkg::word_t        value;
        datapathPkg::word_t        seen;
        datapathPkg::wide_t        rzRead;
        datapathPkg::controlWord_t cw;
        datapathPkg::aluOp_t       op;
        int                        a;
        int                        b;
        int                        c;
        clk        = 1'b0;
        reset      = 1'b1;
        ctrl       = '0;
        mdataIn    = '0;
        inportData = '0;
        lfsrState  = lfsrSeed;
        clearModel();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        // everything reads zero after reset
        checkWord('0, busValue, "bus after reset");
        checkWord('0, pcValue, "PC after reset");
        checkWord('0, irValue, "IR after reset");
        checkWord('0, marValue, "MAR after reset");
        checkWord('0, outputPort, "output port after reset");
        for (int i = 0; i < datapathPkg::gprCount; i++) begin
            readRegister(i, seen);
            checkWord('0, seen, "register after reset");
        end

        // loads through MDR with every register covered first
        for (int i = 0; i < 32; i++) begin
            a = (i < 16) ? i : int'(randBits(4));
            value = randBits(32);
            loadRegister(a, value);
            readRegister(a, seen);
            checkWord(value, seen, "register load");
        end

        repeat (100) begin
            a  = int'(randBits(4));
            b  = int'(randBits(4));
            c  = int'(randBits(4));
            op = simpleOps[randBits(4) % 12];
            if (randBits(1)) loadRegister(a, randBits(32));  // keep operands lively
            startAluOp(a, b, op);
            readRz(rzRead);
            checkWide(mRz, rzRead);
            cw = '0;
            cw.src.rzLoOut = 1'b1;
            cw.load.gprIn[c] = 1'b1;
            runCycle(cw);
            readRegister(c, seen);
            checkWord(mGpr[c], seen, "ALU result");
        end

        // mul and div through HI and LO with some zero divisors
        repeat (40) begin
            a  = int'(randBits(4));
            b  = int'(randBits(4));
            op = randBits(1) ? datapathPkg::opMul : datapathPkg::opDiv;
            loadRegister(a, randBits(32));
            value = (randBits(2) == 0) ? '0 : randBits(32);
            loadRegister(b, value);
            startAluOp(a, b, op);
            readRz(rzRead);
            checkWide(mRz, rzRead);
            cw = '0;
            cw.src.rzHiOut = 1'b1;
            cw.load.hiIn = 1'b1;
            runCycle(cw);
            cw = '0;
            cw.src.rzLoOut = 1'b1;
            cw.load.loIn = 1'b1;
            runCycle(cw);
            cw = '0;
            cw.src.hiOut = 1'b1;
            runCycle(cw);
            checkWord(mHi, busSample, "HI");
            cw = '0;
            cw.src.loOut = 1'b1;
            runCycle(cw);
            checkWord(mLo, busSample, "LO");
        end

        // instruction fetch
        repeat (20) begin
            a = int'(randBits(4));
            loadRegister(a, randBits(32));
            cw = '0;
            cw.src.gprOut[a] = 1'b1;
            cw.load.pcIn = 1'b1;
            runCycle(cw);
            cw = '0;
            cw.src.pcOut = 1'b1;
            cw.load.marIn = 1'b1;
            cw.load.rzIn = 1'b1;
            cw.aluOp = datapathPkg::opInc;
            runCycle(cw);
            cw = '0;
            cw.src.rzLoOut = 1'b1;
            cw.load.pcIn = 1'b1;
            runCycle(cw);
            mdataIn = randBits(32);
            cw = '0;
            cw.load.mdrIn = 1'b1;
            cw.load.read = 1'b1;
            runCycle(cw);
            cw = '0;
            cw.src.mdrOut = 1'b1;
            cw.load.irIn = 1'b1;
            runCycle(cw);
            checkPorts();
        end

        // input port to register to output port
        repeat (20) begin
            a = int'(randBits(4));
            value = randBits(32);
            inportData = value;
            cw = '0;
            cw.src.inportOut = 1'b1;
            cw.load.gprIn[a] = 1'b1;
            runCycle(cw);
            cw = '0;
            cw.src.gprOut[a] = 1'b1;
            cw.load.outputIn = 1'b1;
            runCycle(cw);
            checkWord(value, busSample, "bus from inport register");
            checkWord(value, outputPort, "output port");
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: sources.f
design/datapathPkg.sv
design/registerFile.sv
design/alu.sv
design/busSelect.sv
design/specialRegs.sv
design/datapath.sv
testbench/datapathTb.sv

// File: Bender.yml
package:
  name: datapath

sources:
  - files:
      - design/datapathPkg.sv
      - design/registerFile.sv
      - design/alu.sv
      - design/busSelect.sv
      - design/specialRegs.sv
      - design/datapath.sv
  - target: test
    files:
      - testbench/datapathTb.sv
